// File: verilog/pcs_rx_pkg.sv
`default_nettype none

package pcs_rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Lane geometry and 64b/66b codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int LANES   = 4;
    localparam int BLOCK_W = 64;

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Control block type byte, payload bits [7:0]
    localparam logic [7:0] TYPE_START = 8'h78;
    localparam logic [7:0] TYPE_TERM  = 8'hFF;
    localparam logic [7:0] TYPE_IDLE  = 8'h1E;

    typedef enum logic [2:0] {
        BLK_DATA,
        BLK_START,
        BLK_TERM,
        BLK_IDLE,
        BLK_ERROR
    } block_kind_e;

    typedef enum logic {
        FRAME_IDLE,
        FRAME_IN_PKT
    } frame_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [1:0]         header;
        logic [BLOCK_W-1:0] payload;
    } lane_block_t;

    // Lane 0 sits in the low bits
    typedef struct packed {
        logic                          valid;
        lane_block_t [LANES-1:0]       lanes;
    } lane_group_t;

    typedef struct packed {
        block_kind_e        kind;
        logic [BLOCK_W-1:0] payload;
    } decoded_block_t;

    typedef struct packed {
        logic               data_ok;
        logic               start_ok;
        logic               term_ok;
        logic               err;
        logic [BLOCK_W-1:0] payload;
    } lane_tag_t;

    typedef struct packed {
        logic                       valid;
        logic                       sop;
        logic                       eop;
        logic                       err;
        logic [LANES-1:0]           lane_mask;
        logic [LANES*BLOCK_W-1:0]   data;
    } rx_word_t;

endpackage

`default_nettype wire

// File: verilog/pcs_lane_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_lane_decoder (
    input  pcs_rx_pkg::lane_block_t    lane_i,
    output pcs_rx_pkg::decoded_block_t block_o
);

    logic [1:0] sync_hdr;
    logic [7:0] block_type;
    pcs_rx_pkg::block_kind_e ctrl_kind;

    assign sync_hdr   = lane_i.header;
    assign block_type = lane_i.payload[7:0];

    ////////////////////////////////////////////////////////////////////////////
    // Control block type lookup
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (block_type)
            pcs_rx_pkg::TYPE_START: begin
                ctrl_kind = pcs_rx_pkg::BLK_START;
            end
            pcs_rx_pkg::TYPE_TERM: begin
                ctrl_kind = pcs_rx_pkg::BLK_TERM;
            end
            pcs_rx_pkg::TYPE_IDLE: begin
                ctrl_kind = pcs_rx_pkg::BLK_IDLE;
            end
            default: begin
                // Unknown or unsupported control type
                ctrl_kind = pcs_rx_pkg::BLK_ERROR;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sync header check
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        block_o.payload = lane_i.payload;
        case (sync_hdr)
            pcs_rx_pkg::SYNC_DATA: begin
                block_o.kind = pcs_rx_pkg::BLK_DATA;
            end
            pcs_rx_pkg::SYNC_CTRL: begin
                block_o.kind = ctrl_kind;
            end
            default: begin
                // 2'b00 and 2'b11 are never legal headers
                block_o.kind = pcs_rx_pkg::BLK_ERROR;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/lane_frame_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module lane_frame_tracker (
    input  wire                                                clk_156,
    input  wire                                                async_reset_n,
    input  wire                                                group_valid_i,
    input  pcs_rx_pkg::decoded_block_t [pcs_rx_pkg::LANES-1:0] blocks_i,
    output pcs_rx_pkg::lane_tag_t      [pcs_rx_pkg::LANES-1:0] tags_o,
    output logic                                               tags_valid_o
);

    pcs_rx_pkg::frame_state_e frame_state_q;
    pcs_rx_pkg::frame_state_e frame_state_d;

    ////////////////////////////////////////////////////////////////////////////
    // Lane walk, lane 0 first
    ////////////////////////////////////////////////////////////////////////////

    // Each lane sees the state left behind by the lanes below it
    always_comb begin
        frame_state_d = frame_state_q;
        for (int i = 0; i < pcs_rx_pkg::LANES; i++) begin
            tags_o[i]         = '0;
            tags_o[i].payload = blocks_i[i].payload;
            case (blocks_i[i].kind)
                pcs_rx_pkg::BLK_DATA: begin
                    if (frame_state_d == pcs_rx_pkg::FRAME_IN_PKT) begin
                        tags_o[i].data_ok = 1'b1;
                    end else begin
                        tags_o[i].err = 1'b1;
                    end
                end
                pcs_rx_pkg::BLK_START: begin
                    if (frame_state_d == pcs_rx_pkg::FRAME_IDLE) begin
                        tags_o[i].start_ok = 1'b1;
                        frame_state_d      = pcs_rx_pkg::FRAME_IN_PKT;
                    end else begin
                        // Nested start aborts the open packet
                        tags_o[i].err = 1'b1;
                        frame_state_d = pcs_rx_pkg::FRAME_IDLE;
                    end
                end
                pcs_rx_pkg::BLK_TERM: begin
                    if (frame_state_d == pcs_rx_pkg::FRAME_IN_PKT) begin
                        tags_o[i].term_ok = 1'b1;
                        frame_state_d     = pcs_rx_pkg::FRAME_IDLE;
                    end else begin
                        tags_o[i].err = 1'b1;
                    end
                end
                pcs_rx_pkg::BLK_IDLE: begin
                    // Idle leaves the state alone
                end
                default: begin
                    tags_o[i].err = 1'b1;
                    frame_state_d = pcs_rx_pkg::FRAME_IDLE;
                end
            endcase
        end
    end

    assign tags_valid_o = group_valid_i;

    // State only moves on a valid beat
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            frame_state_q <= pcs_rx_pkg::FRAME_IDLE;
        end else if (group_valid_i) begin
            frame_state_q <= frame_state_d;
        end
    end

    for (genvar g = 0; g < pcs_rx_pkg::LANES; g++) begin : g_tag_chk
        a_start_term_excl: assert property (
            @(posedge clk_156) disable iff (!async_reset_n)
            tags_valid_o |-> !(tags_o[g].start_ok && tags_o[g].term_ok)
        );
    end

endmodule

`default_nettype wire

// File: verilog/rx_word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module rx_word_assembler (
    input  wire                                           clk_156,
    input  wire                                           async_reset_n,
    input  pcs_rx_pkg::lane_tag_t [pcs_rx_pkg::LANES-1:0] tags_i,
    input  wire                                           tags_valid_i,
    output pcs_rx_pkg::rx_word_t                          rx_word_o
);

    pcs_rx_pkg::rx_word_t word_d;
    pcs_rx_pkg::rx_word_t word_q;

    ////////////////////////////////////////////////////////////////////////////
    // Flags, mask and zero-filled data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        word_d = '0;
        if (tags_valid_i) begin
            word_d.valid = 1'b1;
            for (int i = 0; i < pcs_rx_pkg::LANES; i++) begin
                word_d.sop          = word_d.sop | tags_i[i].start_ok;
                word_d.eop          = word_d.eop | tags_i[i].term_ok;
                word_d.err          = word_d.err | tags_i[i].err;
                word_d.lane_mask[i] = tags_i[i].data_ok;
                // Markers and idles leave their lane at zero
                if (tags_i[i].data_ok) begin
                    word_d.data[i*pcs_rx_pkg::BLOCK_W +: pcs_rx_pkg::BLOCK_W] =
                        tags_i[i].payload;
                end
            end
        end
    end

    // One word per valid beat, valid drops otherwise
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            word_q <= '0;
        end else begin
            word_q <= word_d;
        end
    end

    assign rx_word_o = word_q;

    a_flags_need_valid: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        !rx_word_o.valid |-> !(rx_word_o.sop || rx_word_o.eop || rx_word_o.err)
    );

endmodule

`default_nettype wire

// File: verilog/rx_block_stats.sv
`timescale 1ns/1ps
`default_nettype none

module rx_block_stats #(
    parameter int ERR_CNT_WIDTH = 8
) (
    input  wire                                           clk_156,
    input  wire                                           async_reset_n,
    input  pcs_rx_pkg::lane_tag_t [pcs_rx_pkg::LANES-1:0] tags_i,
    input  wire                                           tags_valid_i,
    input  wire                                           clear_errblk_i,
    output logic [ERR_CNT_WIDTH-1:0]                      err_blocks_o,
    output logic [15:0]                                   pkt_count_o
);

    localparam int CNT_W = $clog2(pcs_rx_pkg::LANES + 1);
    localparam logic [ERR_CNT_WIDTH-1:0] ERR_MAX = '1;

    logic [CNT_W-1:0]               err_lanes;
    logic [CNT_W-1:0]               term_lanes;
    logic [ERR_CNT_WIDTH+CNT_W-1:0] err_sum;
    logic [ERR_CNT_WIDTH-1:0]       err_cnt_q;
    logic [15:0]                    pkt_cnt_q;

    // Per-beat lane counts
    always_comb begin
        err_lanes  = '0;
        term_lanes = '0;
        for (int i = 0; i < pcs_rx_pkg::LANES; i++) begin
            err_lanes  = err_lanes + CNT_W'(tags_i[i].err);
            term_lanes = term_lanes + CNT_W'(tags_i[i].term_ok);
        end
    end

    assign err_sum = {{CNT_W{1'b0}}, err_cnt_q} + {{ERR_CNT_WIDTH{1'b0}}, err_lanes};

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            err_cnt_q <= '0;
            pkt_cnt_q <= '0;
        end else begin
            // Clear beats the same-cycle increment
            if (clear_errblk_i) begin
                err_cnt_q <= '0;
            end else if (tags_valid_i) begin
                if (err_sum > {{CNT_W{1'b0}}, ERR_MAX}) begin
                    err_cnt_q <= ERR_MAX;
                end else begin
                    err_cnt_q <= err_sum[ERR_CNT_WIDTH-1:0];
                end
            end
            if (tags_valid_i) begin
                pkt_cnt_q <= pkt_cnt_q + 16'(term_lanes);
            end
        end
    end

    assign err_blocks_o = err_cnt_q;
    assign pkt_count_o  = pkt_cnt_q;

    a_errblk_monotonic: assert property (
        @(posedge clk_156) disable iff (!async_reset_n)
        !clear_errblk_i |=> err_cnt_q >= $past(err_cnt_q)
    );

endmodule

`default_nettype wire

// File: verilog/pcs_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_top #(
    parameter int ERR_CNT_WIDTH = 8
) (
    input  wire                          clk_156,
    input  wire                          async_reset_n,
    input  pcs_rx_pkg::lane_group_t      lane_group_i,
    input  wire                          clear_errblk_i,
    output pcs_rx_pkg::rx_word_t         rx_word_o,
    output logic [ERR_CNT_WIDTH-1:0]     err_blocks_o,
    output logic [15:0]                  pkt_count_o
);

    pcs_rx_pkg::decoded_block_t [pcs_rx_pkg::LANES-1:0] blocks;
    pcs_rx_pkg::lane_tag_t      [pcs_rx_pkg::LANES-1:0] tags;
    logic                                               tags_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane 64b/66b block decode
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < pcs_rx_pkg::LANES; g++) begin : g_lane
        pcs_lane_decoder i_pcs_lane_decoder (
            .lane_i  (lane_group_i.lanes[g]),
            .block_o (blocks[g])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cross-lane framing, word build and counters
    ////////////////////////////////////////////////////////////////////////////

    lane_frame_tracker i_lane_frame_tracker (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .group_valid_i (lane_group_i.valid),
        .blocks_i      (blocks),
        .tags_o        (tags),
        .tags_valid_o  (tags_valid)
    );

    rx_word_assembler i_rx_word_assembler (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .tags_i        (tags),
        .tags_valid_i  (tags_valid),
        .rx_word_o     (rx_word_o)
    );

    rx_block_stats #(
        .ERR_CNT_WIDTH (ERR_CNT_WIDTH)
    ) i_rx_block_stats (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .tags_i         (tags),
        .tags_valid_i   (tags_valid),
        .clear_errblk_i (clear_errblk_i),
        .err_blocks_o   (err_blocks_o),
        .pkt_count_o    (pkt_count_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_pcs_rx_model.svh
`ifndef TB_PCS_RX_MODEL_SVH
`define TB_PCS_RX_MODEL_SVH

// Expected DUT outputs, advanced once per driven beat
pcs_rx_pkg::rx_word_t     exp_word      = '0;
pcs_rx_pkg::frame_state_e model_state   = pcs_rx_pkg::FRAME_IDLE;
int                       model_err_cnt = 0;
logic [15:0]              model_pkt_cnt = '0;

function automatic pcs_rx_pkg::block_kind_e model_kind(input pcs_rx_pkg::lane_block_t lane);
    if (lane.header == pcs_rx_pkg::SYNC_DATA) begin
        return pcs_rx_pkg::BLK_DATA;
    end
    if (lane.header != pcs_rx_pkg::SYNC_CTRL) begin
        return pcs_rx_pkg::BLK_ERROR;
    end
    if (lane.payload[7:0] == pcs_rx_pkg::TYPE_START) begin
        return pcs_rx_pkg::BLK_START;
    end
    if (lane.payload[7:0] == pcs_rx_pkg::TYPE_TERM) begin
        return pcs_rx_pkg::BLK_TERM;
    end
    if (lane.payload[7:0] == pcs_rx_pkg::TYPE_IDLE) begin
        return pcs_rx_pkg::BLK_IDLE;
    end
    return pcs_rx_pkg::BLK_ERROR;
endfunction

// Word, frame state and counters for one beat, lane 0 first
task automatic model_beat(input pcs_rx_pkg::lane_group_t grp, input logic clr);
    pcs_rx_pkg::block_kind_e  kind;
    pcs_rx_pkg::frame_state_e st;
    int                       n_err;
    int                       n_term;
    st       = model_state;
    n_err    = 0;
    n_term   = 0;
    exp_word = '0;
    if (grp.valid) begin
        exp_word.valid = 1'b1;
        for (int i = 0; i < pcs_rx_pkg::LANES; i++) begin
            kind = model_kind(grp.lanes[i]);
            if (kind == pcs_rx_pkg::BLK_DATA && st == pcs_rx_pkg::FRAME_IN_PKT) begin
                exp_word.lane_mask[i] = 1'b1;
                exp_word.data[i*pcs_rx_pkg::BLOCK_W +: pcs_rx_pkg::BLOCK_W] =
                    grp.lanes[i].payload;
            end else if (kind == pcs_rx_pkg::BLK_START && st == pcs_rx_pkg::FRAME_IDLE) begin
                exp_word.sop = 1'b1;
                st           = pcs_rx_pkg::FRAME_IN_PKT;
            end else if (kind == pcs_rx_pkg::BLK_TERM && st == pcs_rx_pkg::FRAME_IN_PKT) begin
                exp_word.eop = 1'b1;
                n_term++;
                st           = pcs_rx_pkg::FRAME_IDLE;
            end else if (kind == pcs_rx_pkg::BLK_DATA || kind == pcs_rx_pkg::BLK_TERM) begin
                // Out of place, state unchanged
                n_err++;
            end else if (kind != pcs_rx_pkg::BLK_IDLE) begin
                // Nested start or bad block closes the packet
                n_err++;
                st = pcs_rx_pkg::FRAME_IDLE;
            end
        end
        exp_word.err  = (n_err != 0);
        model_state   = st;
        model_pkt_cnt = model_pkt_cnt + 16'(n_term);
    end
    if (clr) begin
        model_err_cnt = 0;
    end else if (grp.valid) begin
        model_err_cnt = (model_err_cnt + n_err > ERR_MAX) ? ERR_MAX : model_err_cnt + n_err;
    end
endtask

`endif

// File: verification/tb_pcs_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcs_rx_top;

    localparam int ERR_CNT_WIDTH = 4;
    localparam int ERR_MAX       = (1 << ERR_CNT_WIDTH) - 1;
    localparam int NUM_BEATS     = 2000;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = NUM_BEATS + 200;

    logic                     clk_156;
    logic                     async_reset_n;
    pcs_rx_pkg::lane_group_t  lane_group;
    logic                     clear_errblk;
    pcs_rx_pkg::rx_word_t     rx_word;
    logic [ERR_CNT_WIDTH-1:0] err_blocks;
    logic [15:0]              pkt_count;

    integer seed = 32'h42d8_e77b;
    logic   stim_done = 1'b0;
    int     word_errors = 0;
    int     err_cnt_errors = 0;
    int     pkt_cnt_errors = 0;

`include "tb_pcs_rx_model.svh"

    pcs_rx_top #(
        .ERR_CNT_WIDTH (ERR_CNT_WIDTH)
    ) i_pcs_rx_top (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .lane_group_i   (lane_group),
        .clear_errblk_i (clear_errblk),
        .rx_word_o      (rx_word),
        .err_blocks_o   (err_blocks),
        .pkt_count_o    (pkt_count)
    );

    initial begin
        clk_156 = 1'b0;
        forever #4 clk_156 = ~clk_156;
    end

    initial begin
        async_reset_n = 1'b0;
        repeat (5) @(posedge clk_156);
        @(negedge clk_156);
        async_reset_n = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input pcs_rx_pkg::rx_word_t act,
                              input pcs_rx_pkg::rx_word_t expected);
        if (act !== expected) begin
            word_errors++;
            $display("[ERROR] rx_word_o flags at %0t: got %h, expected %h", $time,
                     {act.valid, act.sop, act.eop, act.err, act.lane_mask},
                     {expected.valid, expected.sop, expected.eop, expected.err,
                      expected.lane_mask});
            $display("[ERROR] rx_word_o.data: got %h, expected %h", act.data, expected.data);
        end
    endtask

    task automatic check_err_count(input logic [ERR_CNT_WIDTH-1:0] act,
                                   input logic [ERR_CNT_WIDTH-1:0] expected);
        if (act !== expected) begin
            err_cnt_errors++;
            $display("[ERROR] err_blocks_o at %0t: got %h, expected %h", $time, act, expected);
        end
    endtask

    task automatic check_pkt_count(input logic [15:0] act, input logic [15:0] expected);
        if (act !== expected) begin
            pkt_cnt_errors++;
            $display("[ERROR] pkt_count_o at %0t: got %h, expected %h", $time, act, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Mostly legal blocks, a few bad headers and unknown types
    function automatic pcs_rx_pkg::lane_block_t random_lane();
        pcs_rx_pkg::lane_block_t lane;
        int                      pick;
        pick         = pick_below(16);
        lane.payload = {$random(seed), $random(seed)};
        lane.header  = pcs_rx_pkg::SYNC_CTRL;
        if (pick < 6) begin
            lane.header = pcs_rx_pkg::SYNC_DATA;
        end else if (pick < 9) begin
            lane.payload[7:0] = pcs_rx_pkg::TYPE_START;
        end else if (pick < 12) begin
            lane.payload[7:0] = pcs_rx_pkg::TYPE_TERM;
        end else if (pick < 14) begin
            lane.payload[7:0] = pcs_rx_pkg::TYPE_IDLE;
        end else if (pick == 14) begin
            lane.header = (pick_below(2) != 0) ? 2'b11 : 2'b00;
        end
        return lane;
    endfunction

    function automatic pcs_rx_pkg::lane_group_t random_group();
        pcs_rx_pkg::lane_group_t grp;
        grp.valid = (pick_below(8) != 0);
        for (int i = 0; i < pcs_rx_pkg::LANES; i++) begin
            grp.lanes[i] = random_lane();
        end
        return grp;
    endfunction

    // Check the previous beat's result, then drive the next beat
    task automatic step_beat(input pcs_rx_pkg::lane_group_t grp, input logic clr);
        @(negedge clk_156);
        check_word(rx_word, exp_word);
        check_err_count(err_blocks, ERR_CNT_WIDTH'(model_err_cnt));
        check_pkt_count(pkt_count, model_pkt_cnt);
        lane_group   = grp;
        clear_errblk = clr;
        model_beat(grp, clr);
    endtask

    initial begin : stimulus
        int reset_wait;
        lane_group   = '0;
        clear_errblk = 1'b0;
        reset_wait   = 0;
        while (async_reset_n !== 1'b1 && reset_wait < RESET_TIMEOUT) begin
            @(negedge clk_156);
            reset_wait++;
        end
        if (async_reset_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("TB FAILED");
            $finish;
        end else begin
            // Quiet beats, outputs stay zero
            repeat (3) step_beat('0, 1'b0);
            for (int n = 0; n < NUM_BEATS; n++) begin
                step_beat(random_group(), pick_below(32) == 0);
            end
            step_beat('0, 1'b0);
            stim_done = 1'b1;
        end
    end

    initial begin : report
        int run_wait;
        run_wait = 0;
        while (!stim_done && run_wait < RUN_TIMEOUT) begin
            @(posedge clk_156);
            run_wait++;
        end
        if (!stim_done) begin
            $display("Stimulus did not finish within %0d cycles", RUN_TIMEOUT);
            $display("TB FAILED");
        end else begin
            $display("Errors: rx_word_o %0d, err_blocks_o %0d, pkt_count_o %0d",
                     word_errors, err_cnt_errors, pkt_cnt_errors);
            if (word_errors + err_cnt_errors + pkt_cnt_errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verification
verilog/pcs_rx_pkg.sv
verilog/pcs_lane_decoder.sv
verilog/lane_frame_tracker.sv
verilog/rx_word_assembler.sv
verilog/rx_block_stats.sv
verilog/pcs_rx_top.sv
verification/tb_pcs_rx_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_pcs_rx_top -o sim_tb_pcs_rx_top \
    && ./obj_dir/sim_tb_pcs_rx_top | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
